//--- cci_shim_subsys.f
+incdir+verif
source/cci_shim_pkg.sv
source/cci_prim_fifo_lutram.sv
source/cci_shim_buffer_lockstep.sv
source/cci_shim_tx_issue.sv
source/cci_shim_csr_apb.sv
source/cci_shim_subsys.sv
verif/cci_shim_subsys_tb.sv

//--- Bender.yml
package:
  name: cci_shim_subsys

sources:
  - files:
      - source/cci_shim_pkg.sv
      - source/cci_prim_fifo_lutram.sv
      - source/cci_shim_buffer_lockstep.sv
      - source/cci_shim_tx_issue.sv
      - source/cci_shim_csr_apb.sv
      - source/cci_shim_subsys.sv
  - target: simulation
    include_dirs:
      - verif
    files:
      - verif/cci_shim_subsys_tb.sv

//--- verif/cci_shim_subsys_tests.svh
// ==============================
// Reset and hold
// ==============================

// Requests wait in the buffer until software sets the enable bit
task automatic reset_and_hold();
    logic [31:0] rdata;
    check_bit("host_c0_tx_rd_valid", 1'b0, host_c0_tx_rd_valid);
    check_bit("host_c1_tx_wr_valid", 1'b0, host_c1_tx_wr_valid);
    check_bit("host_c1_tx_ir_valid", 1'b0, host_c1_tx_ir_valid);
    check_bit("afu_tx_alm_full", 1'b0, afu_tx_alm_full);
    apb_read(REG_CTRL, 1'b0, rdata);
    check_word("REG_CTRL", 32'h0, rdata);
    send_req(make_entry(0));
    send_req(make_entry(1));
    send_req(make_entry(3));
    clear_req();
    repeat (4) @(negedge clk);
    check_word("observed entries", 32'h0, 32'(observed.size()));
    // Fill level counts every held pair
    apb_read(REG_FILL, 1'b0, rdata);
    check_word("REG_FILL", 32'(expected.size()), rdata);
    apb_write(REG_CTRL, 32'h1, 1'b0);
    wait_drain();
    compare_entries();
endtask

// ==============================
// Lock-step order
// ==============================

task automatic lockstep_order();
    // Every mix of the two channels, twice over, back to back
    for (int pass = 0; pass < 2; pass++) begin
        for (int kind = 0; kind < 5; kind++) begin
            send_req(make_entry(kind));
        end
    end
    clear_req();
    wait_drain();
    compare_entries();
endtask

// ==============================
// Almost-full flag
// ==============================

task automatic almost_full_flag();
    logic [31:0] rdata;
    apb_write(REG_CTRL, 32'h0, 1'b0);
    for (int k = 1; k <= N_ENTRIES - THRESHOLD; k++) begin
        send_req(make_entry(k % 5));
        clear_req();
        // Raised once free slots are down to THRESHOLD
        check_bit("afu_tx_alm_full", (N_ENTRIES - k) <= THRESHOLD, afu_tx_alm_full);
    end
    apb_write(REG_CTRL, 32'h1, 1'b0);
    wait_drain();
    @(negedge clk);
    check_bit("afu_tx_alm_full", 1'b0, afu_tx_alm_full);
    apb_read(REG_FILL, 1'b0, rdata);
    check_word("REG_FILL", 32'h0, rdata);
    compare_entries();
endtask

// ==============================
// Host back-pressure
// ==============================

task automatic host_backpressure();
    @(negedge clk);
    host_c0_tx_alm_full = 1'b1;
    for (int k = 0; k < 4; k++) begin
        send_req(make_entry(4 - k));
    end
    clear_req();
    repeat (4) @(negedge clk);
    check_word("observed entries", 32'h0, 32'(observed.size()));
    // Channel 1 alone must stall both channels too
    host_c0_tx_alm_full = 1'b0;
    host_c1_tx_alm_full = 1'b1;
    repeat (4) @(negedge clk);
    check_word("observed entries", 32'h0, 32'(observed.size()));
    host_c1_tx_alm_full = 1'b0;
    wait_drain();
    compare_entries();
endtask

// ==============================
// Counters and APB errors
// ==============================

task automatic counters_and_apb_errors();
    logic [31:0] rdata;
    apb_read(REG_RD_CNT, 1'b0, rdata);
    check_word("REG_RD_CNT", 32'(n_rd), rdata);
    apb_read(REG_WR_CNT, 1'b0, rdata);
    check_word("REG_WR_CNT", 32'(n_wr), rdata);
    apb_read(REG_IRQ_CNT, 1'b0, rdata);
    check_word("REG_IRQ_CNT", 32'(n_ir), rdata);
    // First address past the map, then a write to a read-only register
    apb_read(5'h14, 1'b1, rdata);
    apb_write(REG_FILL, 32'h5, 1'b1);
    apb_read(REG_CTRL, 1'b0, rdata);
    check_word("REG_CTRL", 32'h1, rdata);
endtask

// ==============================
// Random traffic
// ==============================

task automatic random_traffic();
    for (int i = 0; i < 200; i++) begin
        @(negedge clk);
        host_c0_tx_alm_full = (($urandom % 4) == 0);
        host_c1_tx_alm_full = (($urandom % 4) == 0);
        // The accelerator holds off once almost-full is up
        if (!afu_tx_alm_full && (($urandom % 3) != 0)) begin
            drive_entry(make_entry($urandom % 5));
        end else begin
            drive_idle();
        end
    end
    @(negedge clk);
    drive_idle();
    host_c0_tx_alm_full = 1'b0;
    host_c1_tx_alm_full = 1'b0;
    wait_drain();
    compare_entries();
endtask

//--- verif/cci_shim_subsys_tb.sv
`timescale 1ns/10ps

module cci_shim_subsys_tb
    import cci_shim_pkg::*;
();

    localparam int CLK_PERIOD  = 8;
    // Requests sent over all tests, used to size the watchdog
    localparam int TOTAL_REQS  = 221;
    localparam int DRAIN_LIMIT = 64;

    // One buffered pair as seen on either side of the DUT
    typedef struct packed {
        logic [C0_HDR_BITS-1:0] c0_hdr;
        logic                   rd;
        c1_tx_hdr_t             c1_hdr;
        logic [DATA_BITS-1:0]   data;
        logic                   wr;
        logic                   ir;
    } tx_entry_t;

    logic                     clk = 1'b0;
    logic                     rst_n;
    logic [C0_HDR_BITS-1:0]   afu_c0_tx_hdr;
    logic                     afu_c0_tx_rd_valid;
    c1_tx_hdr_t               afu_c1_tx_hdr;
    logic [DATA_BITS-1:0]     afu_c1_tx_data;
    logic                     afu_c1_tx_wr_valid;
    logic                     afu_c1_tx_ir_valid;
    logic                     afu_tx_alm_full;
    logic [C0_HDR_BITS-1:0]   host_c0_tx_hdr;
    logic                     host_c0_tx_rd_valid;
    c1_tx_hdr_t               host_c1_tx_hdr;
    logic [DATA_BITS-1:0]     host_c1_tx_data;
    logic                     host_c1_tx_wr_valid;
    logic                     host_c1_tx_ir_valid;
    logic                     host_c0_tx_alm_full;
    logic                     host_c1_tx_alm_full;
    logic                     psel;
    logic                     penable;
    logic                     pwrite;
    logic [APB_ADDR_BITS-1:0] paddr;
    logic [31:0]              pwdata;
    logic [31:0]              prdata;
    logic                     pready;
    logic                     pslverr;

    // Sent pairs in order, and pairs the host model saw
    tx_entry_t expected[$];
    tx_entry_t observed[$];
    tx_entry_t seen;
    int        n_rd;
    int        n_wr;
    int        n_ir;
    int        mismatch_count;
    int        fail_count;

    always #(CLK_PERIOD / 2) clk = ~clk;

    cci_shim_subsys cci_shim_subsys_inst (.*);

    // ==============================
    // Host model
    // ==============================

    // Every rising edge with a host valid is one accepted request
    always @(posedge clk) begin
        if (rst_n && (host_c0_tx_rd_valid || host_c1_tx_wr_valid || host_c1_tx_ir_valid)) begin
            if (host_c0_tx_alm_full || host_c1_tx_alm_full) begin
                $display("host valid issued while the host reported almost full at %0t", $time);
                fail_count++;
            end
            seen.c0_hdr = host_c0_tx_hdr;
            seen.rd     = host_c0_tx_rd_valid;
            seen.c1_hdr = host_c1_tx_hdr;
            seen.data   = host_c1_tx_data;
            seen.wr     = host_c1_tx_wr_valid;
            seen.ir     = host_c1_tx_ir_valid;
            observed.push_back(seen);
            n_rd += host_c0_tx_rd_valid;
            n_wr += host_c1_tx_wr_valid;
            n_ir += host_c1_tx_ir_valid;
        end
    end

    // ==============================
    // Compare tasks
    // ==============================

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("mismatch %s: expected %h, actual %h", name, exp, act);
            mismatch_count++;
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("mismatch %s: expected %h, actual %h", name, exp, act);
            mismatch_count++;
        end
    endtask

    task automatic check_c0(input logic [C0_HDR_BITS-1:0] exp_hdr, input logic exp_rd,
                            input logic [C0_HDR_BITS-1:0] act_hdr, input logic act_rd);
        check_bit("host_c0_tx_rd_valid", exp_rd, act_rd);
        // Header only means something when the read valid is set
        if (exp_rd && (act_hdr !== exp_hdr)) begin
            $display("mismatch host_c0_tx_hdr: expected %h, actual %h", exp_hdr, act_hdr);
            mismatch_count++;
        end
    endtask

    task automatic check_c1(input c1_tx_hdr_t exp_hdr, input logic [DATA_BITS-1:0] exp_data,
                            input logic exp_wr, input logic exp_ir,
                            input c1_tx_hdr_t act_hdr, input logic [DATA_BITS-1:0] act_data,
                            input logic act_wr, input logic act_ir);
        check_bit("host_c1_tx_wr_valid", exp_wr, act_wr);
        check_bit("host_c1_tx_ir_valid", exp_ir, act_ir);
        // The write view carries address, tag and one data beat
        if (exp_wr) begin
            check_word("host_c1_tx_hdr.wr.addr", 32'(exp_hdr.wr.addr), 32'(act_hdr.wr.addr));
            check_word("host_c1_tx_hdr.wr.tag", 32'(exp_hdr.wr.tag), 32'(act_hdr.wr.tag));
            if (act_data !== exp_data) begin
                $display("mismatch host_c1_tx_data: expected %h, actual %h", exp_data, act_data);
                mismatch_count++;
            end
        end
        // Interrupt view only has the vector
        if (exp_ir) begin
            check_word("host_c1_tx_hdr.ir.vector", 32'(exp_hdr.ir.vector),
                       32'(act_hdr.ir.vector));
        end
    endtask

    // ==============================
    // Stimulus helpers
    // ==============================

    task automatic apb_write(input logic [APB_ADDR_BITS-1:0] addr, input logic [31:0] data,
                             input logic exp_err);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        // Zero wait states, so the transfer ends at this edge
        @(posedge clk);
        check_bit("pready", 1'b1, pready);
        check_bit("pslverr", exp_err, pslverr);
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [APB_ADDR_BITS-1:0] addr, input logic exp_err,
                            output logic [31:0] data);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(negedge clk);
        penable = 1'b1;
        @(posedge clk);
        check_bit("pready", 1'b1, pready);
        check_bit("pslverr", exp_err, pslverr);
        data = prdata;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    // Kind 0 read, 1 write, 2 interrupt, 3 read plus write, 4 read plus interrupt
    function automatic tx_entry_t make_entry(input int kind);
        tx_entry_t e;
        e        = '0;
        e.c0_hdr = C0_HDR_BITS'($urandom);
        e.data   = {$urandom, $urandom};
        e.rd     = (kind == 0) || (kind == 3) || (kind == 4);
        e.wr     = (kind == 1) || (kind == 3);
        e.ir     = (kind == 2) || (kind == 4);
        if (e.ir) begin
            e.c1_hdr.ir.vector = 8'($urandom);
            e.c1_hdr.ir.rsvd   = '0;
        end else begin
            e.c1_hdr.wr.addr = 16'($urandom);
            e.c1_hdr.wr.tag  = 8'($urandom);
        end
        return e;
    endfunction

    // Drives a pair in the current cycle and records it as expected
    task automatic drive_entry(input tx_entry_t e);
        afu_c0_tx_hdr      = e.c0_hdr;
        afu_c0_tx_rd_valid = e.rd;
        afu_c1_tx_hdr      = e.c1_hdr;
        afu_c1_tx_data     = e.data;
        afu_c1_tx_wr_valid = e.wr;
        afu_c1_tx_ir_valid = e.ir;
        expected.push_back(e);
    endtask

    task automatic drive_idle();
        afu_c0_tx_rd_valid = 1'b0;
        afu_c1_tx_wr_valid = 1'b0;
        afu_c1_tx_ir_valid = 1'b0;
    endtask

    task automatic send_req(input tx_entry_t e);
        @(negedge clk);
        drive_entry(e);
    endtask

    task automatic clear_req();
        @(negedge clk);
        drive_idle();
    endtask

    // Waits until the host has seen as many pairs as were sent
    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while ((observed.size() < expected.size()) && (cycles < DRAIN_LIMIT)) begin
            @(negedge clk);
            cycles++;
        end
        if (observed.size() < expected.size()) begin
            $display("buffer did not drain: %0d of %0d entries reached the host",
                     observed.size(), expected.size());
            fail_count++;
        end
    endtask

    task automatic compare_entries();
        tx_entry_t exp_e;
        tx_entry_t act_e;
        while (expected.size() > 0) begin
            if (observed.size() == 0) begin
                $display("missing entries: %0d sent pairs never reached the host",
                         expected.size());
                fail_count++;
                expected.delete();
            end else begin
                exp_e = expected.pop_front();
                act_e = observed.pop_front();
                check_c0(exp_e.c0_hdr, exp_e.rd, act_e.c0_hdr, act_e.rd);
                check_c1(exp_e.c1_hdr, exp_e.data, exp_e.wr, exp_e.ir,
                         act_e.c1_hdr, act_e.data, act_e.wr, act_e.ir);
            end
        end
        if (observed.size() > 0) begin
            $display("extra entries: host issued %0d pairs that were never sent", observed.size());
            fail_count++;
            observed.delete();
        end
    endtask

    `include "cci_shim_subsys_tests.svh"

    // ==============================
    // Run control
    // ==============================

    initial begin
        #((TOTAL_REQS + 200) * CLK_PERIOD);
        $display("timeout: run did not finish within %0d ns", (TOTAL_REQS + 200) * CLK_PERIOD);
        $display("mismatches: %0d, other errors: %0d", mismatch_count, fail_count + 1);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        void'($urandom(32'h850b));
        rst_n               = 1'b0;
        afu_c0_tx_hdr       = '0;
        afu_c0_tx_rd_valid  = 1'b0;
        afu_c1_tx_hdr       = '0;
        afu_c1_tx_data      = '0;
        afu_c1_tx_wr_valid  = 1'b0;
        afu_c1_tx_ir_valid  = 1'b0;
        host_c0_tx_alm_full = 1'b0;
        host_c1_tx_alm_full = 1'b0;
        psel                = 1'b0;
        penable             = 1'b0;
        pwrite              = 1'b0;
        paddr               = '0;
        pwdata              = '0;
        n_rd                = 0;
        n_wr                = 0;
        n_ir                = 0;
        mismatch_count      = 0;
        fail_count          = 0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        reset_and_hold();
        lockstep_order();
        almost_full_flag();
        host_backpressure();
        counters_and_apb_errors();
        random_traffic();

        repeat (2) @(negedge clk);
        $display("mismatches: %0d, other errors: %0d", mismatch_count, fail_count);
        if ((mismatch_count == 0) && (fail_count == 0)) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- source/cci_shim_subsys.sv
`timescale 1ns/10ps

module cci_shim_subsys
    import cci_shim_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,

    // Accelerator request side
    input  logic [C0_HDR_BITS-1:0]   afu_c0_tx_hdr,
    input  logic                     afu_c0_tx_rd_valid,
    input  c1_tx_hdr_t               afu_c1_tx_hdr,
    input  logic [DATA_BITS-1:0]     afu_c1_tx_data,
    input  logic                     afu_c1_tx_wr_valid,
    input  logic                     afu_c1_tx_ir_valid,
    output logic                     afu_tx_alm_full,

    // Host request side, no ready and only almost-full back-pressure
    output logic [C0_HDR_BITS-1:0]   host_c0_tx_hdr,
    output logic                     host_c0_tx_rd_valid,
    output c1_tx_hdr_t               host_c1_tx_hdr,
    output logic [DATA_BITS-1:0]     host_c1_tx_data,
    output logic                     host_c1_tx_wr_valid,
    output logic                     host_c1_tx_ir_valid,
    input  logic                     host_c0_tx_alm_full,
    input  logic                     host_c1_tx_alm_full,

    // Software register port
    input  logic                     psel,
    input  logic                     penable,
    input  logic                     pwrite,
    input  logic [APB_ADDR_BITS-1:0] paddr,
    input  logic [31:0]              pwdata,
    output logic [31:0]              prdata,
    output logic                     pready,
    output logic                     pslverr
);

    logic                 tx_deq;
    logic                 head_rd_valid;
    logic                 head_wr_valid;
    logic                 head_ir_valid;
    logic                 issue_en;
    logic [FILL_BITS-1:0] fill;
    logic [CNT_BITS-1:0]  rd_cnt;
    logic [CNT_BITS-1:0]  wr_cnt;
    logic [CNT_BITS-1:0]  irq_cnt;

    // Headers and data go straight from the buffer head to the host
    cci_shim_buffer_lockstep buffer_inst (
        .clk                 (clk),
        .rst_n               (rst_n),
        .afu_c0_tx_hdr       (afu_c0_tx_hdr),
        .afu_c0_tx_rd_valid  (afu_c0_tx_rd_valid),
        .afu_c1_tx_hdr       (afu_c1_tx_hdr),
        .afu_c1_tx_data      (afu_c1_tx_data),
        .afu_c1_tx_wr_valid  (afu_c1_tx_wr_valid),
        .afu_c1_tx_ir_valid  (afu_c1_tx_ir_valid),
        .afu_tx_alm_full     (afu_tx_alm_full),
        .deq                 (tx_deq),
        .fill                (fill),
        .host_c0_tx_hdr      (host_c0_tx_hdr),
        .host_c0_tx_rd_valid (head_rd_valid),
        .host_c1_tx_hdr      (host_c1_tx_hdr),
        .host_c1_tx_data     (host_c1_tx_data),
        .host_c1_tx_wr_valid (head_wr_valid),
        .host_c1_tx_ir_valid (head_ir_valid)
    );

    // Valids toward the host are the issue stage's, shown only when popped
    cci_shim_tx_issue issue_inst (
        .clk                 (clk),
        .rst_n               (rst_n),
        .head_rd_valid       (head_rd_valid),
        .head_wr_valid       (head_wr_valid),
        .head_ir_valid       (head_ir_valid),
        .host_c0_tx_alm_full (host_c0_tx_alm_full),
        .host_c1_tx_alm_full (host_c1_tx_alm_full),
        .issue_en            (issue_en),
        .deq                 (tx_deq),
        .issue_rd            (host_c0_tx_rd_valid),
        .issue_wr            (host_c1_tx_wr_valid),
        .issue_ir            (host_c1_tx_ir_valid),
        .rd_cnt              (rd_cnt),
        .wr_cnt              (wr_cnt),
        .irq_cnt             (irq_cnt)
    );

    cci_shim_csr_apb csr_inst (
        .clk                 (clk),
        .rst_n               (rst_n),
        .psel                (psel),
        .penable             (penable),
        .pwrite              (pwrite),
        .paddr               (paddr),
        .pwdata              (pwdata),
        .prdata              (prdata),
        .pready              (pready),
        .pslverr             (pslverr),
        .rd_cnt              (rd_cnt),
        .wr_cnt              (wr_cnt),
        .irq_cnt             (irq_cnt),
        .fill                (fill),
        .issue_en            (issue_en)
    );

endmodule

//--- source/cci_shim_csr_apb.sv
`timescale 1ns/10ps

module cci_shim_csr_apb
    import cci_shim_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,

    // APB completer, zero wait states
    input  logic                     psel,
    input  logic                     penable,
    input  logic                     pwrite,
    input  logic [APB_ADDR_BITS-1:0] paddr,
    input  logic [31:0]              pwdata,
    output logic [31:0]              prdata,
    output logic                     pready,
    output logic                     pslverr,

    // Status from the issue stage and buffer
    input  logic [CNT_BITS-1:0]      rd_cnt,
    input  logic [CNT_BITS-1:0]      wr_cnt,
    input  logic [CNT_BITS-1:0]      irq_cnt,
    input  logic [FILL_BITS-1:0]     fill,

    output logic                     issue_en
);

    logic access;
    logic addr_hit;
    logic ctrl_sel;
    logic ctrl_wr;

    // ==============================
    // Address decode
    // ==============================

    // Second cycle of a transfer, where data moves and the response is given
    assign access = psel && penable;

    always_comb begin
        case (paddr)
            REG_CTRL, REG_RD_CNT, REG_WR_CNT, REG_IRQ_CNT, REG_FILL: addr_hit = 1'b1;
            default:                                             addr_hit = 1'b0;
        endcase
    end

    assign ctrl_sel = (paddr == REG_CTRL);
    assign ctrl_wr  = access && pwrite && ctrl_sel;

    // Every transfer completes in its first access cycle
    assign pready = 1'b1;

    // Unknown addresses fail, and only the control register is writable
    assign pslverr = access && (!addr_hit || (pwrite && !ctrl_sel));

    // ==============================
    // Control register
    // ==============================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            issue_en <= 1'b0;
        end else if (ctrl_wr) begin
            issue_en <= pwdata[0];
        end
    end

    // ==============================
    // Read mux
    // ==============================

    // Read data is driven only during a read access, zero otherwise
    always_comb begin
        prdata = '0;
        if (access && !pwrite) begin
            case (paddr)
                REG_CTRL:    prdata = {31'b0, issue_en};
                REG_RD_CNT:  prdata = 32'(rd_cnt);
                REG_WR_CNT:  prdata = 32'(wr_cnt);
                REG_IRQ_CNT: prdata = 32'(irq_cnt);
                REG_FILL:    prdata = 32'(fill);
                default:     prdata = '0;
            endcase
        end
    end

endmodule

//--- source/cci_shim_tx_issue.sv
`timescale 1ns/10ps

module cci_shim_tx_issue
    import cci_shim_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,

    // Masked valids of the buffer head
    input  logic                head_rd_valid,
    input  logic                head_wr_valid,
    input  logic                head_ir_valid,

    input  logic                host_c0_tx_alm_full,
    input  logic                host_c1_tx_alm_full,
    input  logic                issue_en,

    // Pop toward the buffer and the valids presented to the host
    output logic                deq,
    output logic                issue_rd,
    output logic                issue_wr,
    output logic                issue_ir,

    output logic [CNT_BITS-1:0] rd_cnt,
    output logic [CNT_BITS-1:0] wr_cnt,
    output logic [CNT_BITS-1:0] irq_cnt
);

    logic                     head_any;
    logic                     host_open;
    logic [2:0]               cnt_inc;
    logic [2:0][CNT_BITS-1:0] cnt_q;

    // ==============================
    // Issue decision
    // ==============================

    assign head_any = head_rd_valid || head_wr_valid || head_ir_valid;

    // Either host channel being nearly full stalls both, since entries are atomic
    assign host_open = issue_en && !host_c0_tx_alm_full && !host_c1_tx_alm_full;

    assign deq = head_any && host_open;

    // A valid reaches the host only in the cycle that also pops it
    assign issue_rd = head_rd_valid && deq;
    assign issue_wr = head_wr_valid && deq;
    assign issue_ir = head_ir_valid && deq;

    // ==============================
    // Issue counters
    // ==============================

    assign cnt_inc = {issue_ir, issue_wr, issue_rd};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt_q <= '0;
        end else begin
            for (int i = 0; i < 3; i++) begin
                // Counters stick at all ones instead of wrapping
                if (cnt_inc[i] && (cnt_q[i] != '1)) begin
                    cnt_q[i] <= cnt_q[i] + 1'b1;
                end
            end
        end
    end

    assign rd_cnt  = cnt_q[0];
    assign wr_cnt  = cnt_q[1];
    assign irq_cnt = cnt_q[2];

endmodule

//--- source/cci_shim_buffer_lockstep.sv
`timescale 1ns/10ps

module cci_shim_buffer_lockstep
    import cci_shim_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,

    // Raw requests from the accelerator
    input  logic [C0_HDR_BITS-1:0] afu_c0_tx_hdr,
    input  logic                   afu_c0_tx_rd_valid,
    input  c1_tx_hdr_t             afu_c1_tx_hdr,
    input  logic [DATA_BITS-1:0]   afu_c1_tx_data,
    input  logic                   afu_c1_tx_wr_valid,
    input  logic                   afu_c1_tx_ir_valid,
    output logic                   afu_tx_alm_full,

    // One pop moves both channels of the head entry
    input  logic                   deq,
    output logic [FILL_BITS-1:0]   fill,

    // Head entry, valids already masked while the buffer is empty
    output logic [C0_HDR_BITS-1:0] host_c0_tx_hdr,
    output logic                   host_c0_tx_rd_valid,
    output c1_tx_hdr_t             host_c1_tx_hdr,
    output logic [DATA_BITS-1:0]   host_c1_tx_data,
    output logic                   host_c1_tx_wr_valid,
    output logic                   host_c1_tx_ir_valid
);

    // ==============================
    // Entry packing
    // ==============================

    logic               enq_en;
    logic [TX_BITS-1:0] enq_data;
    logic [TX_BITS-1:0] head;
    logic               head_present;

    logic [C0_TX_BITS-1:0] head_c0;
    logic [C1_TX_BITS-1:0] head_c1;
    logic                  head_rd_valid;
    logic                  head_wr_valid;
    logic                  head_ir_valid;

    // Any valid on either channel claims an entry for both, keeping them aligned
    assign enq_en = afu_c0_tx_rd_valid || afu_c1_tx_wr_valid || afu_c1_tx_ir_valid;

    // Channel 0 slice sits in the upper bits, channel 1 below it
    assign enq_data = {
        afu_c0_tx_hdr,
        afu_c0_tx_rd_valid,
        afu_c1_tx_hdr,
        afu_c1_tx_data,
        afu_c1_tx_wr_valid,
        afu_c1_tx_ir_valid
    };

    cci_prim_fifo_lutram #(
        .N_DATA_BITS (TX_BITS),
        .N_ENTRIES   (N_ENTRIES),
        .THRESHOLD   (THRESHOLD)
    ) fifo_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .enq_data    (enq_data),
        .enq_en      (enq_en),
        .deq_en      (deq),
        .first       (head),
        .not_empty   (head_present),
        .not_full    (),
        .almost_full (afu_tx_alm_full),
        .fill        (fill)
    );

    // ==============================
    // Head unpacking
    // ==============================

    // Field order mirrors enq_data exactly
    assign head_c0 = head[TX_BITS-1 -: C0_TX_BITS];
    assign head_c1 = head[C1_TX_BITS-1:0];

    assign host_c0_tx_hdr = head_c0[C0_TX_BITS-1:1];
    assign head_rd_valid  = head_c0[0];

    assign host_c1_tx_hdr  = head_c1[C1_TX_BITS-1 -: C1_HDR_BITS];
    assign host_c1_tx_data = head_c1[DATA_BITS+1:2];
    assign head_wr_valid   = head_c1[1];
    assign head_ir_valid   = head_c1[0];

    // Stale memory contents must never look like a request
    assign host_c0_tx_rd_valid = head_rd_valid && head_present;
    assign host_c1_tx_wr_valid = head_wr_valid && head_present;
    assign host_c1_tx_ir_valid = head_ir_valid && head_present;

endmodule

//--- source/cci_prim_fifo_lutram.sv
`timescale 1ns/10ps

module cci_prim_fifo_lutram #(
    parameter int N_DATA_BITS = 32,
    parameter int N_ENTRIES   = 8,
    parameter int THRESHOLD   = 4
) (
    input  logic                               clk,
    input  logic                               rst_n,

    input  logic [N_DATA_BITS-1:0]             enq_data,
    input  logic                               enq_en,
    input  logic                               deq_en,

    // Head of the queue, valid whenever not_empty is set
    output logic [N_DATA_BITS-1:0]             first,
    output logic                               not_empty,
    output logic                               not_full,
    output logic                               almost_full,
    output logic [$clog2(N_ENTRIES+1)-1:0]     fill
);

    localparam int PTR_BITS = (N_ENTRIES > 1) ? $clog2(N_ENTRIES) : 1;
    localparam int CNT_W    = $clog2(N_ENTRIES + 1);

    // Storage maps onto distributed memory with an asynchronous read port
    logic [N_DATA_BITS-1:0] mem [N_ENTRIES];

    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [CNT_W-1:0]    count;
    logic [CNT_W-1:0]    count_next;

    logic do_enq;
    logic do_deq;

    // A write into a full queue is lost, and a pop of an empty queue is ignored
    assign do_enq = enq_en && not_full;
    assign do_deq = deq_en && not_empty;

    assign not_empty = (count != '0);
    assign not_full  = (count != CNT_W'(N_ENTRIES));
    assign fill      = count;

    // First word is visible without a read request
    assign first = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_enq) begin
            mem[wr_ptr] <= enq_data;
        end
    end

    // Occupancy after this cycle's push and pop
    always_comb begin
        count_next = count;
        if (do_enq && !do_deq) begin
            count_next = count + 1'b1;
        end else if (!do_enq && do_deq) begin
            count_next = count - 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            almost_full <= 1'b0;
        end else begin
            count <= count_next;

            // Pointers wrap explicitly so any depth works
            if (do_enq) begin
                wr_ptr <= (wr_ptr == PTR_BITS'(N_ENTRIES - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_deq) begin
                rd_ptr <= (rd_ptr == PTR_BITS'(N_ENTRIES - 1)) ? '0 : rd_ptr + 1'b1;
            end

            // Free slots at or below THRESHOLD means occupancy at or above
            // N_ENTRIES - THRESHOLD, judged on the count being loaded now
            almost_full <= (count_next >= CNT_W'(N_ENTRIES - THRESHOLD));
        end
    end

endmodule

//--- source/cci_shim_pkg.sv
package cci_shim_pkg;

    // ==============================
    // Request widths
    // ==============================

    // Channel 1 write data, scaled down from a full cache line
    localparam int DATA_BITS = 64;

    // Read header carries a 16-bit line address and an 8-bit tag
    localparam int C0_HDR_BITS = 24;

    // Channel 1 header is shared by writes and interrupts
    localparam int C1_HDR_BITS = 24;

    // One channel 0 FIFO slice holds the header and the read valid bit
    localparam int C0_TX_BITS = C0_HDR_BITS + 1;

    // One channel 1 FIFO slice holds header, data, write valid and interrupt valid
    localparam int C1_TX_BITS = C1_HDR_BITS + DATA_BITS + 2;

    // Both channels travel in a single FIFO entry
    localparam int TX_BITS = C0_TX_BITS + C1_TX_BITS;

    // ==============================
    // Buffer sizing and counters
    // ==============================

    localparam int N_ENTRIES = 8;

    // Almost-full is raised once this many slots or fewer are free
    localparam int THRESHOLD = 4;

    localparam int CNT_BITS = 16;

    // Occupancy runs from 0 to N_ENTRIES inclusive
    localparam int FILL_BITS = 4;

    // A channel 1 header is read either as a write header or as an interrupt
    // header, and the write valid or interrupt valid bit beside it picks the view
    typedef union packed {
        struct packed {
            logic [15:0] addr;
            logic [7:0]  tag;
        } wr;
        struct packed {
            logic [7:0]  vector;
            logic [15:0] rsvd;
        } ir;
    } c1_tx_hdr_t;

    // ==============================
    // APB register map
    // ==============================

    localparam int APB_ADDR_BITS = 5;

    // Bit 0 enables issue toward the host
    localparam logic [APB_ADDR_BITS-1:0] REG_CTRL    = 5'h00;
    localparam logic [APB_ADDR_BITS-1:0] REG_RD_CNT  = 5'h04;
    localparam logic [APB_ADDR_BITS-1:0] REG_WR_CNT  = 5'h08;
    localparam logic [APB_ADDR_BITS-1:0] REG_IRQ_CNT = 5'h0C;
    localparam logic [APB_ADDR_BITS-1:0] REG_FILL    = 5'h10;

endpackage
